// ==== cpu_handler.f ====
src/cpu_bus_pkg.sv
src/cpu_bus_if.sv
src/frame_sequencer.sv
src/bus_serializer.sv
src/bus_deserializer.sv
src/bus_handler.sv
src/cpu_core.sv
src/cpu_handler_top.sv
tb/tb_cpu_handler.sv

// ==== Bender.yml ====
package:
  name: cpu_handler

sources:
  - src/cpu_bus_pkg.sv
  - src/cpu_bus_if.sv
  - src/frame_sequencer.sv
  - src/bus_serializer.sv
  - src/bus_deserializer.sv
  - src/bus_handler.sv
  - src/cpu_core.sv
  - src/cpu_handler_top.sv
  - target: test
    files:
      - tb/tb_cpu_handler.sv

// ==== tb/tb_cpu_handler.sv ====
`default_nettype none

module tb_cpu_handler;
  import cpu_bus_pkg::*;

  localparam int N_FRAMES  = 400;
  localparam int MAX_PAUSE = 3;    // run-low cycles at most per frame boundary
  localparam int MEM_WORDS = 256;
  localparam longint WATCHDOG_TIME =
    20 * FRAME_LEN * (N_FRAMES + MAX_PAUSE * N_FRAMES + 10);

  logic  clk;
  logic  rst;
  byte_t ui_in;
  byte_t uo_out;
  byte_t uio_in;
  byte_t uio_out;
  byte_t uio_oe;

  cpu_handler_top i_cpu_handler_top (
    .clk     (clk),
    .rst     (rst),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  word_t       mem [MEM_WORDS];  // external memory seen through the pins
  logic [15:0] lfsr;
  int          errors;
  int          checks;

  // reference processor
  logic   m_exec;
  word_t  m_pc;
  word_t  m_acc;
  word_t  m_ir;
  word_t  m_addr;   // request expected on the pins this frame
  word_t  m_wdata;
  logic   m_write;
  phase_t m_phase;  // phase the DUT should be in right now

  int    frames;
  int    pause_left;
  logic  run;
  word_t pin_addr;   // rebuilt from uo_out in phases 1 to 4
  word_t pin_wdata;  // rebuilt from uio_out
  int    n_jmp;
  int    n_jz_taken;
  int    n_jz_skip;
  int    n_nop;
  int    n_sta;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // lower half is code with short operands and upper half plain data
  task automatic fill_memory;
    word_t r;
    word_t operand;
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i < MEM_WORDS / 2) begin
        random_bits(3, r);  // 6 and 7 decode as no-operation
        random_bits(8, operand);
        mem[i] = {1'b0, r[2:0], 20'h0_0000, operand[7:0]};
      end else begin
        random_bits(32, r);
        mem[i] = r;
      end
    end
  endtask

  task automatic pick_pause;
    word_t r;
    random_bits(3, r);
    pause_left = (r > MAX_PAUSE) ? 0 : int'(r);
  endtask

  task automatic update_request;
    m_addr  = m_exec ? {4'h0, m_ir[27:0]} : m_pc;
    m_write = m_exec && (m_ir[31:28] == STA);
    m_wdata = m_acc;
  endtask

  // what the processor does at the end of a frame
  task automatic model_step;
    word_t      rd;
    logic [3:0] op;
    word_t      operand;
    rd = mem[m_addr[7:0]];
    if (!m_exec) begin
      op      = rd[31:28];
      operand = {4'h0, rd[27:0]};
      m_ir    = rd;
      m_pc    = m_pc + 32'd1;
      case (op)
        LDA, STA, ADD, XOR: begin
          m_exec = 1'b1;
        end
        JMP: begin
          m_pc = operand;
          n_jmp++;
        end
        JZ: begin
          if (m_acc == '0) begin
            m_pc = operand;
            n_jz_taken++;
          end else begin
            n_jz_skip++;
          end
        end
        default: begin
          n_nop++;
        end
      endcase
    end else begin
      case (m_ir[31:28])
        LDA: m_acc = rd;
        ADD: m_acc = m_acc + rd;
        XOR: m_acc = m_acc ^ rd;
        default: n_sta++;
      endcase
      m_exec = 1'b0;
    end
    update_request();
  endtask

  task automatic check_pins;
    int idx;
    if (m_phase >= 4'd1 && m_phase <= 4'd4) begin
      idx = m_phase - 1;
      pin_addr[8*idx +: 8]  = uo_out;  // lsb first
      pin_wdata[8*idx +: 8] = uio_out;
    end else if (m_phase == PH_FLAG) begin
      check_word("address", pin_addr, m_addr);
      check_word("write data", pin_wdata, m_wdata);
      check_bit("write flag", uo_out[0], m_write);
      check_byte("uo_out upper bits", uo_out & 8'hfe, 8'h00);
      check_byte("uio_out flag phase", uio_out, 8'h00);
      if (frames == 0) begin
        check_word("first fetch address", pin_addr, RESET_PC);
        check_bit("first write flag", uo_out[0], 1'b0);
      end
    end else begin
      check_byte("uo_out idle", uo_out, 8'h00);
      check_byte("uio_out idle", uio_out, 8'h00);
    end
    check_byte("uio_oe", uio_oe, {8{m_write}});
  endtask

  task automatic drive_inputs;
    word_t r;
    word_t rd_word;
    int    shift;
    if (m_phase == 4'd0) begin
      if (pause_left > 0) begin
        run = 1'b0;
        pause_left--;
      end else begin
        run = 1'b1;
      end
    end else begin
      random_bits(1, r);
      run = r[0];  // ignored away from phase 0
    end
    ui_in = {7'h00, run};
    if (!m_write && m_phase >= PH_READ) begin
      rd_word = mem[pin_addr[7:0]];
      shift   = FRAME_LEN - 1 - int'(m_phase);  // msb at phase 6
      uio_in  = rd_word[8*shift +: 8];
    end else begin
      random_bits(8, r);
      uio_in = r[7:0];
    end
  endtask

  task automatic advance_model;
    if (m_phase == phase_t'(FRAME_LEN - 1)) begin
      if (m_write) begin
        mem[pin_addr[7:0]] = pin_wdata;  // store as seen on the pins
      end
      model_step();
      frames++;
      pin_addr  = '0;
      pin_wdata = '0;
      m_phase   = '0;
      pick_pause();
    end else if (m_phase != 4'd0 || run) begin
      m_phase = m_phase + 4'd1;
    end
  endtask

  initial begin
    rst        = 1'b1;
    ui_in      = '0;
    uio_in     = '0;
    run        = 1'b0;
    errors     = 0;
    checks     = 0;
    frames     = 0;
    n_jmp      = 0;
    n_jz_taken = 0;
    n_jz_skip  = 0;
    n_nop      = 0;
    n_sta      = 0;
    lfsr       = 16'd84;
    fill_memory();
    m_exec    = 1'b0;
    m_pc      = RESET_PC;
    m_acc     = '0;
    m_ir      = '0;
    m_phase   = '0;
    pin_addr  = '0;
    pin_wdata = '0;
    update_request();
    pick_pause();

    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_byte("uo_out in reset", uo_out, 8'h00);
      check_byte("uio_out in reset", uio_out, 8'h00);
      check_byte("uio_oe in reset", uio_oe, 8'h00);
    end
    rst = 1'b0;

    // one pass per clock on the falling edge
    while (frames < N_FRAMES) begin
      check_pins();
      drive_inputs();
      advance_model();
      @(negedge clk);
    end

    $display("frames %0d, jmp %0d, jz taken %0d, jz skipped %0d, nop %0d, sta %0d",
             frames, n_jmp, n_jz_taken, n_jz_skip, n_nop, n_sta);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired before %0d frames completed", N_FRAMES);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/cpu_handler_top.sv ====
`default_nettype none

module cpu_handler_top (
  input  wire                     clk,
  input  wire                     rst,
  input  wire cpu_bus_pkg::byte_t ui_in,
  output cpu_bus_pkg::byte_t      uo_out,
  input  wire cpu_bus_pkg::byte_t uio_in,
  output cpu_bus_pkg::byte_t      uio_out,
  output cpu_bus_pkg::byte_t      uio_oe
);

  cpu_bus_if bus ();  // request and read word between core and handler

  cpu_core i_cpu_core (
    .clk (clk),
    .rst (rst),
    .bus (bus)
  );

  bus_handler i_bus_handler (
    .clk     (clk),
    .rst     (rst),
    .run     (ui_in[0]),  // run level, only ui_in bit in use
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .bus     (bus)
  );

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`default_nettype none

module cpu_core (
  input wire     clk,
  input wire     rst,
  cpu_bus_if.cpu bus
);
  import cpu_bus_pkg::*;

  typedef enum logic {
    ST_FETCH,
    ST_EXEC
  } state_t;

  state_t  state;
  word_t   pc;
  word_t   acc;
  word_t   ir;             // instruction under execution
  opcode_t ir_op;
  word_t   ir_operand;
  opcode_t fetch_op;       // opcode arriving at the fetch step
  word_t   fetch_operand;

  assign ir_op      = opcode_t'(ir[31:28]);
  assign ir_operand = {4'h0, ir[27:0]};  // zero filled upper bits

  assign fetch_op      = opcode_t'(bus.rdata[31:28]);
  assign fetch_operand = {4'h0, bus.rdata[27:0]};

  // request moves only when state, pc or ir move at step
  assign bus.addr  = (state == ST_EXEC) ? ir_operand : pc;
  assign bus.wdata = acc;
  assign bus.write = (state == ST_EXEC) && (ir_op == STA);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_FETCH;
      pc    <= RESET_PC;
      acc   <= '0;
    end else if (bus.step) begin
      if (state == ST_FETCH) begin
        pc <= pc + 32'd1;  // taken jumps override below
        case (fetch_op)
          LDA, STA, ADD, XOR: begin
            state <= ST_EXEC;  // needs an operand frame
          end
          JMP: begin
            pc <= fetch_operand;
          end
          JZ: begin
            if (acc == '0) begin
              pc <= fetch_operand;
            end
          end
          default: begin
            // no-operation goes straight to the next fetch
          end
        endcase
      end else begin
        case (ir_op)
          LDA: begin
            acc <= bus.rdata;
          end
          ADD: begin
            acc <= acc + bus.rdata;  // wraps mod 2^32
          end
          XOR: begin
            acc <= acc ^ bus.rdata;
          end
          default: begin
            // STA stored during the frame itself
          end
        endcase
        state <= ST_FETCH;
      end
    end
  end

  // latched at the end of every fetch frame
  always_ff @(posedge clk) begin
    if (bus.step && state == ST_FETCH) begin
      ir <= bus.rdata;
    end
  end

  a_write_exec: assert property (
    @(posedge clk) disable iff (rst)
    bus.write |-> state == ST_EXEC
  );

endmodule

`default_nettype wire

// ==== src/bus_handler.sv ====
`default_nettype none

module bus_handler (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     run,
  input  wire cpu_bus_pkg::byte_t uio_in,
  output cpu_bus_pkg::byte_t      uo_out,
  output cpu_bus_pkg::byte_t      uio_out,
  output cpu_bus_pkg::byte_t      uio_oe,
  cpu_bus_if.handler              bus
);
  import cpu_bus_pkg::*;

  phase_t phase;
  logic   step;
  byte_t  addr_byte;
  byte_t  data_byte;
  word_t  rdata;

  frame_sequencer i_frame_sequencer (
    .clk   (clk),
    .rst   (rst),
    .run   (run),
    .phase (phase),
    .step  (step)
  );

  bus_serializer i_bus_serializer (
    .clk       (clk),
    .rst       (rst),
    .phase     (phase),
    .addr      (bus.addr),
    .wdata     (bus.wdata),
    .write     (bus.write),
    .addr_byte (addr_byte),
    .data_byte (data_byte)
  );

  bus_deserializer i_bus_deserializer (
    .clk    (clk),
    .rst    (rst),
    .phase  (phase),
    .uio_in (uio_in),
    .rdata  (rdata)
  );

  assign uo_out  = addr_byte;
  assign uio_out = data_byte;
  assign uio_oe  = {8{bus.write}};  // drive the shared pins for stores only

  assign bus.rdata = rdata;
  assign bus.step  = step;

  // direction flips only at a frame boundary, right after the core updates
  a_oe_frame: assert property (
    @(posedge clk) disable iff (rst)
    $changed(uio_oe) |-> $past(step)
  );

endmodule

`default_nettype wire

// ==== src/bus_deserializer.sv ====
`default_nettype none

module bus_deserializer (
  input  wire                      clk,
  input  wire                      rst,
  input  wire cpu_bus_pkg::phase_t phase,
  input  wire cpu_bus_pkg::byte_t  uio_in,
  output cpu_bus_pkg::word_t       rdata
);
  import cpu_bus_pkg::*;

  byte_t rd_q [3];  // bytes from phases 6, 7 and 8

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 3; i++) begin
        rd_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (phase == PH_READ + phase_t'(i)) begin
          rd_q[i] <= uio_in;
        end
      end
    end
  end

  // msb first on the pins
  // last byte comes straight off uio_in, so rdata is only whole in phase 9
  assign rdata = {rd_q[0], rd_q[1], rd_q[2], uio_in};

endmodule

`default_nettype wire

// ==== src/bus_serializer.sv ====
`default_nettype none

module bus_serializer (
  input  wire                      clk,
  input  wire                      rst,
  input  wire cpu_bus_pkg::phase_t phase,
  input  wire cpu_bus_pkg::word_t  addr,
  input  wire cpu_bus_pkg::word_t  wdata,
  input  wire                      write,
  output cpu_bus_pkg::byte_t       addr_byte,
  output cpu_bus_pkg::byte_t       data_byte
);
  import cpu_bus_pkg::*;

  byte_t addr_nxt;  // byte due on uo_out in the next phase
  byte_t data_nxt;  // byte due on uio_out in the next phase
  byte_t addr_q;
  byte_t data_q;

  // pick by the current phase what the following phase must show
  always_comb begin
    addr_nxt = '0;
    data_nxt = '0;
    case (phase)
      4'd0: begin
        addr_nxt = addr[7:0];  // lsb first
        data_nxt = wdata[7:0];
      end
      4'd1: begin
        addr_nxt = addr[15:8];
        data_nxt = wdata[15:8];
      end
      4'd2: begin
        addr_nxt = addr[23:16];
        data_nxt = wdata[23:16];
      end
      4'd3: begin
        addr_nxt = addr[31:24];
        data_nxt = wdata[31:24];
      end
      PH_FLAG - 4'd1: begin
        addr_nxt = {7'b0, write};  // flag alone on bit 0
      end
      default: begin
        // read and idle phases stay quiet
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
      data_q <= '0;
    end else begin
      addr_q <= addr_nxt;
      data_q <= data_nxt;
    end
  end

  // phase 0 can repeat while paused and then the registers already hold byte 0
  assign addr_byte = (phase == '0) ? '0 : addr_q;
  assign data_byte = (phase == '0) ? '0 : data_q;

  a_data_quiet: assert property (
    @(posedge clk) disable iff (rst)
    !(phase inside {[4'd1:4'd4]}) |-> data_byte == '0
  );

endmodule

`default_nettype wire

// ==== src/frame_sequencer.sv ====
`default_nettype none

module frame_sequencer (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 run,
  output cpu_bus_pkg::phase_t phase,
  output logic                step
);
  import cpu_bus_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= '0;
    end else if (phase == phase_t'(FRAME_LEN - 1)) begin
      phase <= '0;  // wrap to the frame boundary
    end else if (phase != '0 || run) begin
      phase <= phase + 4'd1;
    end
    // phase 0 with run low just waits here
  end

  assign step = (phase == phase_t'(FRAME_LEN - 1));

  a_phase_range: assert property (
    @(posedge clk) disable iff (rst)
    phase < FRAME_LEN
  );

  // one step per frame, never back to back
  a_step_single: assert property (
    @(posedge clk) disable iff (rst)
    step |=> !step
  );

endmodule

`default_nettype wire

// ==== src/cpu_bus_if.sv ====
`default_nettype none

interface cpu_bus_if;
  import cpu_bus_pkg::*;

  word_t addr;   // request address
  word_t wdata;  // store data, shown on uio_out
  logic  write;  // request is a store
  word_t rdata;  // read word, complete during phase 9
  logic  step;   // last phase of the frame

  // processor side
  modport cpu (
    output addr,
    output wdata,
    output write,
    input  rdata,
    input  step
  );

  modport handler (
    input  addr,
    input  wdata,
    input  write,
    output rdata,
    output step
  );

endinterface

`default_nettype wire

// ==== src/cpu_bus_pkg.sv ====
`default_nettype none

package cpu_bus_pkg;

  typedef logic [31:0] word_t;  // address, data and instruction word
  typedef logic [7:0] byte_t;   // one pin byte
  typedef logic [3:0] phase_t;  // frame phase, 0 to 9

  // upper four bits of an instruction word
  typedef enum logic [3:0] {
    LDA = 4'd0,
    STA = 4'd1,
    ADD = 4'd2,
    XOR = 4'd3,
    JMP = 4'd4,
    JZ  = 4'd5
  } opcode_t;

  localparam int FRAME_LEN = 10;  // phases per bus frame

  localparam phase_t PH_FLAG = 4'd5;  // write flag on uo_out[0]
  localparam phase_t PH_READ = 4'd6;  // first read byte on uio_in

  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
